// ==== common/fabric_pkg.sv ====
`default_nettype none

package fabric_pkg;

	// Tile geometry, fixed by the config word layout.
	localparam int NUM_SIDES = 4;
	localparam int TRACKS_PER_SIDE = 4;

	// Unit field codes of the config address.
	localparam logic [15:0] UNIT_SB = 16'd7;
	localparam logic [15:0] UNIT_CB0 = 16'd6;
	localparam logic [15:0] UNIT_CB1 = 16'd5;
	localparam logic [15:0] UNIT_CLB = 16'd4;

	// Logic block operations.
	localparam logic [1:0] OP_AND = 2'd0;
	localparam logic [1:0] OP_OR = 2'd1;
	localparam logic [1:0] OP_XOR = 2'd2;
	localparam logic [1:0] OP_NAND = 2'd3;

	// Switch box sources, relative to the side being driven.
	localparam logic [1:0] ROUTE_PE = 2'd0;
	localparam logic [1:0] ROUTE_NEXT = 2'd1;
	localparam logic [1:0] ROUTE_OPP = 2'd2;
	localparam logic [1:0] ROUTE_PREV = 2'd3;

	typedef struct packed {
		logic [15:0] unit; // Upper half.
		logic [15:0] tile; // Lower half.
	} config_addr_t;

	typedef struct packed {
		logic [TRACKS_PER_SIDE-1:0] side3;
		logic [TRACKS_PER_SIDE-1:0] side2;
		logic [TRACKS_PER_SIDE-1:0] side1;
		logic [TRACKS_PER_SIDE-1:0] side0;
	} tracks_t;

	// Switch box view, entry side*4 + track.
	typedef struct packed {
		logic [NUM_SIDES*TRACKS_PER_SIDE-1:0][1:0] route;
	} sb_word_t;

	typedef struct packed {
		logic [28:0] unused;
		logic [2:0] sel;
	} cb_word_t;

	typedef struct packed {
		logic [29:0] unused;
		logic [1:0] op;
	} clb_word_t;

	// One data word, read differently by each unit.
	typedef union packed {
		logic [31:0] raw;
		sb_word_t sb;
		cb_word_t cb;
		clb_word_t clb;
	} config_word_u;

endpackage

`default_nettype wire

// ==== design/config_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module config_decoder (
	input fabric_pkg::config_addr_t config_addr,
	input logic [15:0] tile_id,
	output logic en_sb,
	output logic en_cb0,
	output logic en_cb1,
	output logic en_clb
);

	import fabric_pkg::*;

	logic tile_match;

	assign tile_match = (config_addr.tile == tile_id);

	// Unit 0 and unknown codes fall through as idle.
	always_comb begin
		en_sb = 1'b0;
		en_cb0 = 1'b0;
		en_cb1 = 1'b0;
		en_clb = 1'b0;
		if (tile_match) begin
			case (config_addr.unit)
				UNIT_SB: begin
					en_sb = 1'b1;
				end
				UNIT_CB0: begin
					en_cb0 = 1'b1;
				end
				UNIT_CB1: begin
					en_cb1 = 1'b1;
				end
				UNIT_CLB: begin
					en_clb = 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/connect_box.sv ====
`timescale 1ns/1ps
`default_nettype none

module connect_box (
	input logic clk,
	input logic rst_n,
	input logic config_en,
	input fabric_pkg::config_word_u config_data,
	input logic [3:0] side_in,
	input logic [3:0] side_out,
	output logic operand
);

	logic [2:0] sel_q;
	logic [7:0] candidates;

	// Track select register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_q <= 3'd0;
		end else if (config_en) begin
			sel_q <= config_data.cb.sel;
		end
	end

	// Selects 0..3 are input tracks, 4..7 the routed output tracks.
	assign candidates = {side_out, side_in};

	always_comb begin
		case (sel_q)
			3'd0: operand = candidates[0];
			3'd1: operand = candidates[1];
			3'd2: operand = candidates[2];
			3'd3: operand = candidates[3];
			3'd4: operand = candidates[4];
			3'd5: operand = candidates[5];
			3'd6: operand = candidates[6];
			default: operand = candidates[7];
		endcase
	end

endmodule

`default_nettype wire

// ==== design/logic_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module logic_block (
	input logic clk,
	input logic rst_n,
	input logic config_en,
	input fabric_pkg::config_word_u config_data,
	input logic in0,
	input logic in1,
	output logic result
);

	import fabric_pkg::*;

	logic [1:0] op_q;
	logic op_value;

	// Op register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_q <= OP_AND;
		end else if (config_en) begin
			op_q <= config_data.clb.op;
		end
	end

	always_comb begin
		case (op_q)
			OP_AND: begin
				op_value = in0 & in1;
			end
			OP_OR: begin
				op_value = in0 | in1;
			end
			OP_XOR: begin
				op_value = in0 ^ in1;
			end
			default: begin
				op_value = ~(in0 & in1); // OP_NAND.
			end
		endcase
	end

	// Output flop, cuts the loop back through the switch box.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= 1'b0;
		end else begin
			result <= op_value;
		end
	end

endmodule

`default_nettype wire

// ==== design/pe_tile.sv ====
`timescale 1ns/1ps
`default_nettype none

module pe_tile (
	input logic clk,
	input logic rst_n,
	input fabric_pkg::config_addr_t config_addr,
	input fabric_pkg::config_word_u config_data,
	input logic [15:0] tile_id,
	input fabric_pkg::tracks_t in_tracks,
	output fabric_pkg::tracks_t out_tracks
);

	logic en_sb;
	logic en_cb0;
	logic en_cb1;
	logic en_clb;
	logic op0;
	logic op1;
	logic pe_out;

	config_decoder decoder (
		.config_addr(config_addr),
		.tile_id(tile_id),
		.en_sb(en_sb),
		.en_cb0(en_cb0),
		.en_cb1(en_cb1),
		.en_clb(en_clb)
	);

	// Operand 0 from side 0.
	connect_box cb0 (
		.clk(clk),
		.rst_n(rst_n),
		.config_en(en_cb0),
		.config_data(config_data),
		.side_in(in_tracks.side0),
		.side_out(out_tracks.side0),
		.operand(op0)
	);

	// Operand 1 from side 1.
	connect_box cb1 (
		.clk(clk),
		.rst_n(rst_n),
		.config_en(en_cb1),
		.config_data(config_data),
		.side_in(in_tracks.side1),
		.side_out(out_tracks.side1),
		.operand(op1)
	);

	logic_block compute_block (
		.clk(clk),
		.rst_n(rst_n),
		.config_en(en_clb),
		.config_data(config_data),
		.in0(op0),
		.in1(op1),
		.result(pe_out)
	);

	switch_box sb (
		.clk(clk),
		.rst_n(rst_n),
		.config_en(en_sb),
		.config_data(config_data),
		.in_tracks(in_tracks),
		.pe_out(pe_out),
		.out_tracks(out_tracks)
	);

endmodule

`default_nettype wire

// ==== list.f ====
common/fabric_pkg.sv
design/config_decoder.sv
design/connect_box.sv
design/logic_block.sv
switch_box/switch_box.sv
design/pe_tile.sv
test/tb_pe_tile.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f list.f --top-module tb_pe_tile -o tb_pe_tile

output=$(./obj_dir/tb_pe_tile 2>&1) || true
echo "$output"

if grep -qx "Simulation finished: PASS" <<< "$output"; then
	exit 0
fi
exit 1

// ==== switch_box/switch_box.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_box (
	input logic clk,
	input logic rst_n,
	input logic config_en,
	input fabric_pkg::config_word_u config_data,
	input fabric_pkg::tracks_t in_tracks,
	input logic pe_out,
	output fabric_pkg::tracks_t out_tracks
);

	import fabric_pkg::*;

	logic [NUM_SIDES*TRACKS_PER_SIDE-1:0][1:0] route_q;
	logic [NUM_SIDES-1:0][TRACKS_PER_SIDE-1:0] in_arr;
	logic [NUM_SIDES-1:0][TRACKS_PER_SIDE-1:0] out_arr;

	// Route register, all ROUTE_PE out of reset.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			route_q <= '0;
		end else if (config_en) begin
			route_q <= config_data.sb.route;
		end
	end

	// Side 3 lands in the top slice, side 0 in the bottom one.
	assign in_arr = in_tracks;

	always_comb begin
		for (int s = 0; s < NUM_SIDES; s++) begin
			for (int t = 0; t < TRACKS_PER_SIDE; t++) begin
				case (route_q[s*TRACKS_PER_SIDE+t])
					ROUTE_PE: begin
						out_arr[s][t] = pe_out;
					end
					ROUTE_NEXT: begin
						out_arr[s][t] = in_arr[(s+1)%NUM_SIDES][t];
					end
					ROUTE_OPP: begin
						out_arr[s][t] = in_arr[(s+2)%NUM_SIDES][t];
					end
					default: begin
						out_arr[s][t] = in_arr[(s+3)%NUM_SIDES][t]; // ROUTE_PREV.
					end
				endcase
			end
		end
	end

	// Same track index on the source side, no turns between tracks.
	assign out_tracks = out_arr;

endmodule

`default_nettype wire

// ==== test/tb_pe_tile.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pe_tile;

	import fabric_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 3;
	localparam int DIRECTED_WRITES = 16;
	localparam int SETTLE_CYCLES = 4;
	localparam int RANDOM_CYCLES = 2000;
	localparam int TEST_CYCLES = RESET_CYCLES + 3 * DIRECTED_WRITES * (1 + SETTLE_CYCLES)
		+ RANDOM_CYCLES;
	localparam int TIMEOUT_NS = (TEST_CYCLES + 50) * CLK_PERIOD;
	localparam logic [15:0] TILE_ID = 16'h0042;

	logic clk;
	logic rst_n;
	config_addr_t config_addr;
	config_word_u config_data;
	logic [15:0] tile_id;
	tracks_t in_tracks;
	tracks_t out_tracks;
	integer seed;

	// Reference copies of the tile's configuration and the pe_out flop.
	logic [15:0][1:0] m_route;
	logic [2:0] m_sel0;
	logic [2:0] m_sel1;
	logic [1:0] m_op;
	logic m_pe;

	pe_tile pe_tile_inst (
		.clk(clk),
		.rst_n(rst_n),
		.config_addr(config_addr),
		.config_data(config_data),
		.tile_id(tile_id),
		.in_tracks(in_tracks),
		.out_tracks(out_tracks)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the test did not reach its end in the expected time");
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog expired");
	end

	function automatic config_addr_t make_addr(input logic [15:0] unit, input logic [15:0] tile);
		config_addr_t addr;
		addr.unit = unit;
		addr.tile = tile;
		return addr;
	endfunction

	// Kinds 0..3 are real units, 4 is idle, 5 an unknown code, 6 and 7 real units again.
	function automatic logic [15:0] unit_for(input logic [2:0] kind, input logic [7:0] extra);
		case (kind)
			3'd0, 3'd6: return UNIT_SB;
			3'd1, 3'd7: return UNIT_CB0;
			3'd2: return UNIT_CB1;
			3'd3: return UNIT_CLB;
			3'd4: return 16'd0;
			default: return 16'd8 + {8'd0, extra};
		endcase
	endfunction

	function automatic logic [3:0] side_of(input tracks_t tr, input int side);
		case (side)
			0: return tr.side0;
			1: return tr.side1;
			2: return tr.side2;
			default: return tr.side3;
		endcase
	endfunction

	// Output track idx = side*4 + track, source side offset by the route select.
	function automatic tracks_t model_tracks(input tracks_t tin);
		logic [15:0] flat;
		logic [3:0] src;
		int offset;
		flat = '0;
		for (int idx = 0; idx < 16; idx++) begin
			if (m_route[idx] == ROUTE_PE) begin
				flat[idx] = m_pe;
			end else begin
				offset = (m_route[idx] == ROUTE_NEXT) ? 1 : (m_route[idx] == ROUTE_OPP) ? 2 : 3;
				src = side_of(tin, (idx / 4 + offset) % 4);
				flat[idx] = src[idx % 4];
			end
		end
		return tracks_t'(flat);
	endfunction

	function automatic logic pick_operand(input logic [2:0] sel, input logic [3:0] side_in,
		input logic [3:0] side_out);
		if (sel < 3'd4) begin
			return side_in[sel[1:0]];
		end else begin
			return side_out[sel[1:0]];
		end
	endfunction

	function automatic logic apply_op(input logic [1:0] op, input logic a, input logic b);
		case (op)
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			default: return ~(a & b);
		endcase
	endfunction

	task automatic check_tracks(input tracks_t got, input tracks_t expected);
		if (got !== expected) begin
			$display("Fail at %0t ns: out_tracks got %h, expected %h", $time, got, expected);
			$display("Simulation finished: FAIL");
			$fatal(1, "out_tracks mismatch");
		end
	endtask

	// Called right after a rising edge, while the previous inputs still stand.
	task automatic update_model();
		tracks_t routed;
		logic op0;
		logic op1;
		routed = model_tracks(in_tracks);
		op0 = pick_operand(m_sel0, in_tracks.side0, routed.side0);
		op1 = pick_operand(m_sel1, in_tracks.side1, routed.side1);
		m_pe = apply_op(m_op, op0, op1); // Uses the op from before the edge.
		if (config_addr.tile == tile_id) begin
			if (config_addr.unit == UNIT_SB) m_route = config_data.raw;
			if (config_addr.unit == UNIT_CB0) m_sel0 = config_data.raw[2:0];
			if (config_addr.unit == UNIT_CB1) m_sel1 = config_data.raw[2:0];
			if (config_addr.unit == UNIT_CLB) m_op = config_data.raw[1:0];
		end
	endtask

	task automatic run_cycle(input config_addr_t addr, input config_word_u data);
		logic [31:0] r;
		r = $random(seed);
		#1;
		config_addr = addr;
		config_data = data;
		in_tracks = r[15:0];
		#2;
		check_tracks(out_tracks, model_tracks(in_tracks));
		@(posedge clk);
		update_model();
	endtask

	task automatic idle_cycles(input int count);
		config_word_u data;
		repeat (count) begin
			data.raw = $random(seed); // Data without a matching address is ignored.
			run_cycle(make_addr(16'd0, TILE_ID), data);
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [15:0] unit;
		logic [15:0] tile;
		config_word_u data;
		config_addr_t addr;
		seed = 72;
		rst_n = 1'b0;
		config_addr = '0;
		config_data = '0;
		tile_id = TILE_ID;
		in_tracks = '0;
		m_route = '0;
		m_sel0 = 3'd0;
		m_sel1 = 3'd0;
		m_op = OP_AND;
		m_pe = 1'b0;

		// Outputs stay zero through reset, whatever the tracks carry.
		@(posedge clk);
		for (int i = 0; i < RESET_CYCLES; i++) begin
			r = $random(seed);
			#1;
			if (i == RESET_CYCLES - 1) rst_n = 1'b1;
			in_tracks = r[15:0];
			#2;
			check_tracks(out_tracks, '0);
			@(posedge clk);
		end
		update_model();

		for (int i = 0; i < DIRECTED_WRITES; i++) begin
			data.raw = $random(seed);
			run_cycle(make_addr(UNIT_SB, TILE_ID), data);
			idle_cycles(SETTLE_CYCLES);
		end

		// Operand selects and every op, with fresh routes now and then.
		for (int i = 0; i < DIRECTED_WRITES; i++) begin
			data.raw = $random(seed);
			case (i % 4)
				0: unit = UNIT_CB0;
				1: unit = UNIT_CB1;
				2: begin
					unit = UNIT_CLB;
					data.clb.op = 2'(i / 4);
				end
				default: unit = UNIT_SB;
			endcase
			run_cycle(make_addr(unit, TILE_ID), data);
			idle_cycles(SETTLE_CYCLES);
		end

		for (int i = 0; i < DIRECTED_WRITES; i++) begin
			r = $random(seed);
			data.raw = $random(seed);
			case (i % 3)
				0: addr = make_addr(unit_for({1'b0, r[1:0]}, 8'd0), TILE_ID ^ (16'h0001 << r[7:4]));
				1: addr = make_addr(16'd0, TILE_ID);
				default: addr = make_addr(unit_for(3'd5, r[15:8]), TILE_ID);
			endcase
			run_cycle(addr, data);
			idle_cycles(SETTLE_CYCLES);
		end

		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			r = $random(seed);
			data.raw = $random(seed);
			addr = make_addr(16'd0, TILE_ID);
			if (r[7:0] < 8'd85) begin
				tile = (r[9:8] == 2'd0) ? TILE_ID + {8'd0, r[23:16]} + 16'd1 : TILE_ID;
				addr = make_addr(unit_for(r[12:10], r[31:24]), tile);
			end
			run_cycle(addr, data);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire
